// File: hdl/convDefs.sv
`default_nettype none

package convDefs;

    // memory geometry
    localparam int NB_ADDRESS = 10;

    // datapath widths
    // result holds four times the largest pixel
    localparam int NB_PIXEL   = 8;
    localparam int NB_RESULT  = 10;

    // read address to result write including the memory read register
    localparam int LATENCY    = 5;

    typedef logic [NB_PIXEL-1:0]  pixel_t;
    typedef logic [NB_RESULT-1:0] result_t;

    // smoothing weights
    // y[n] = W0*x[n] + W1*x[n-1] + W2*x[n-2]
    // samples before the block count as zero
    localparam result_t KERNEL_W0 = result_t'(1);
    localparam result_t KERNEL_W1 = result_t'(2);
    localparam result_t KERNEL_W2 = result_t'(1);

endpackage

`default_nettype wire

// File: hdl/apbMap.sv
`default_nettype none

package apbMap;

    localparam int NB_APB_ADDR = 4;
    localparam int NB_APB_DATA = 32;

    // register offsets
    localparam logic [NB_APB_ADDR-1:0] REG_CTRL   = 4'h0;
    localparam logic [NB_APB_ADDR-1:0] REG_LENGTH = 4'h4;
    localparam logic [NB_APB_ADDR-1:0] REG_DATA   = 4'h8;
    localparam logic [NB_APB_ADDR-1:0] REG_STATUS = 4'hC;

    // control bits
    localparam int CTRL_LOAD  = 0;
    localparam int CTRL_START = 1;

    // status bits
    // block done stays set until a status write
    localparam int ST_BUSY       = 0;
    localparam int ST_EOP        = 1;
    localparam int ST_BLOCK_DONE = 2;

endpackage

`default_nettype wire

// File: hdl/lineRam.sv
`default_nettype none

module lineRam import convDefs::*; #(
    parameter type word_t = logic [NB_PIXEL-1:0]
) (
    input  logic                  i_CLK,
    input  logic                  i_we,
    input  logic [NB_ADDRESS-1:0] i_wrAddr,
    input  word_t                 i_wrData,
    input  logic [NB_ADDRESS-1:0] i_rdAddr,
    output word_t                 o_rdData
);

    word_t memArray [2**NB_ADDRESS];

    always_ff @(posedge i_CLK) begin
        if (i_we) begin
            memArray[i_wrAddr] <= i_wrData;
        end
    end

    // data follows the read address by one cycle
    always_ff @(posedge i_CLK) begin
        o_rdData <= memArray[i_rdAddr];
    end

endmodule

`default_nettype wire

// File: hdl/blockSequencer.sv
`default_nettype none

module blockSequencer import convDefs::*; (
    input  logic                  i_CLK,
    input  logic                  i_reset,
    input  logic                  i_load,
    input  logic                  i_start,
    input  logic                  i_dataPulse,
    input  logic [NB_ADDRESS-1:0] i_imgLength,
    input  logic                  i_resultWe,
    output logic                  o_imgWe,
    output logic [NB_ADDRESS-1:0] o_imgWrAddr,
    output logic [NB_ADDRESS-1:0] o_imgRdAddr,
    output logic [NB_ADDRESS-1:0] o_resWrAddr,
    output logic [NB_ADDRESS-1:0] o_resRdAddr,
    output logic                  o_convValid,
    output logic                  o_changeBlock,
    output logic                  o_eop,
    output logic                  o_busy
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_TRANSFER,
        S_PROCESS,
        S_RELEASE
    } state_t;

    state_t                  state;
    logic [NB_ADDRESS-1:0]   counterAdd;
    logic [NB_ADDRESS-1:0]   lagCounter;
    logic                    readout;
    logic                    convValid;
    logic                    changeBlock;
    logic                    eop;

    always_ff @(posedge i_CLK) begin
        if (i_reset) begin
            state       <= S_IDLE;
            counterAdd  <= '0;
            lagCounter  <= '0;
            readout     <= 1'b0;
            convValid   <= 1'b0;
            changeBlock <= 1'b0;
            eop         <= 1'b0;
        end else begin
            changeBlock <= 1'b0;
            case (state)
                S_IDLE: begin
                    counterAdd <= '0;
                    lagCounter <= '0;
                    if (i_load && !i_start && !eop) begin
                        state   <= S_TRANSFER;
                        readout <= 1'b0;
                    end else if (!i_load && i_start && !eop) begin
                        state     <= S_PROCESS;
                        convValid <= 1'b1;
                    end else if (!i_load && !i_start && eop) begin
                        // results waiting for the host to read out
                        state   <= S_TRANSFER;
                        readout <= 1'b1;
                    end
                end
                S_TRANSFER: begin
                    if (i_dataPulse) begin
                        if (counterAdd == i_imgLength) begin
                            changeBlock <= 1'b1;
                            state       <= S_IDLE;
                            if (readout) begin
                                eop <= 1'b0;
                            end
                        end else begin
                            counterAdd <= counterAdd + 1'b1;
                        end
                    end
                end
                S_PROCESS: begin
                    // one read address per cycle until the last index
                    if (counterAdd == i_imgLength) begin
                        convValid <= 1'b0;
                    end else begin
                        counterAdd <= counterAdd + 1'b1;
                    end
                    // write side trails by the pipeline latency
                    if (i_resultWe) begin
                        if (lagCounter == i_imgLength) begin
                            eop   <= 1'b1;
                            state <= S_RELEASE;
                        end else begin
                            lagCounter <= lagCounter + 1'b1;
                        end
                    end
                end
                S_RELEASE: begin
                    if (!i_start) begin
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    assign o_imgWe       = (state == S_TRANSFER) && !readout && i_dataPulse;
    assign o_imgWrAddr   = counterAdd;
    assign o_imgRdAddr   = counterAdd;
    assign o_resWrAddr   = lagCounter;
    assign o_resRdAddr   = counterAdd;
    assign o_convValid   = convValid;
    assign o_changeBlock = changeBlock;
    assign o_eop         = eop;
    // waiting for start release does not count as busy
    assign o_busy        = (state == S_TRANSFER) || (state == S_PROCESS);

endmodule

`default_nettype wire

// File: hdl/smoothPipe.sv
`default_nettype none

module smoothPipe import convDefs::*; (
    input  logic    i_CLK,
    input  logic    i_reset,
    input  logic    i_valid,
    input  pixel_t  i_pixel,
    output logic    o_valid,
    output result_t o_result
);

    // stages after product, partial sum and full sum
    localparam int N_OUT = LATENCY - 4;

    logic [LATENCY-1:0] validLine;
    pixel_t             tap1;
    pixel_t             tap2;
    result_t            prodNew;
    result_t            prodMid;
    result_t            prodOld;
    result_t            partSum;
    result_t            oldDelay;
    result_t            fullSum;
    result_t            outLine [N_OUT];

    // i_valid leads the pixel by the memory read cycle
    always_ff @(posedge i_CLK) begin
        if (i_reset) begin
            validLine <= '0;
        end else begin
            validLine <= {validLine[LATENCY-2:0], i_valid};
        end
    end

    // history cleared at the start of each block
    always_ff @(posedge i_CLK) begin
        if (i_valid && !validLine[0]) begin
            tap1 <= '0;
            tap2 <= '0;
        end else if (validLine[0]) begin
            tap1 <= i_pixel;
            tap2 <= tap1;
        end
    end

    always_ff @(posedge i_CLK) begin
        prodNew    <= result_t'(i_pixel) * KERNEL_W0;
        prodMid    <= result_t'(tap1) * KERNEL_W1;
        prodOld    <= result_t'(tap2) * KERNEL_W2;
        partSum    <= prodNew + prodMid;
        oldDelay   <= prodOld;
        fullSum    <= partSum + oldDelay;
        outLine[0] <= fullSum;
        for (int k = 1; k < N_OUT; k++) begin
            outLine[k] <= outLine[k-1];
        end
    end

    assign o_valid  = validLine[LATENCY-1];
    assign o_result = outLine[N_OUT-1];

endmodule

`default_nettype wire

// File: hdl/apbRegs.sv
`default_nettype none

module apbRegs import convDefs::*, apbMap::*; (
    input  logic                   i_CLK,
    input  logic                   i_reset,
    input  logic                   i_psel,
    input  logic                   i_penable,
    input  logic                   i_pwrite,
    input  logic [NB_APB_ADDR-1:0] i_paddr,
    input  logic [NB_APB_DATA-1:0] i_pwdata,
    input  logic                   i_busy,
    input  logic                   i_eop,
    input  logic                   i_changeBlock,
    input  result_t                i_resultData,
    output logic [NB_APB_DATA-1:0] o_prdata,
    output logic                   o_pready,
    output logic                   o_pslverr,
    output logic                   o_load,
    output logic                   o_start,
    output logic [NB_ADDRESS-1:0]  o_imgLength,
    output logic                   o_dataPulse,
    output pixel_t                 o_pixelData
);

    logic                   ctrlLoad;
    logic                   ctrlStart;
    logic [NB_ADDRESS-1:0]  lengthReg;
    logic                   blockDone;
    logic                   waitSeen;
    logic                   dataPulse;
    pixel_t                 pixelReg;
    logic                   dataRead;
    logic                   apbDone;
    logic [NB_APB_DATA-1:0] statusWord;

    // data reads get one wait state for the registered result word
    assign dataRead = i_psel && i_penable && !i_pwrite && (i_paddr == REG_DATA);
    assign o_pready = !dataRead || waitSeen;
    assign apbDone  = i_psel && i_penable && o_pready;

    always_ff @(posedge i_CLK) begin
        if (i_reset) begin
            waitSeen  <= 1'b0;
            dataPulse <= 1'b0;
        end else begin
            waitSeen  <= dataRead && !waitSeen;
            dataPulse <= apbDone && (i_paddr == REG_DATA);
        end
    end

    always_ff @(posedge i_CLK) begin
        if (i_reset) begin
            ctrlLoad  <= 1'b0;
            ctrlStart <= 1'b0;
            lengthReg <= '0;
            blockDone <= 1'b0;
        end else begin
            if (apbDone && i_pwrite && (i_paddr == REG_CTRL)) begin
                ctrlLoad  <= i_pwdata[CTRL_LOAD];
                ctrlStart <= i_pwdata[CTRL_START];
            end
            if (apbDone && i_pwrite && (i_paddr == REG_LENGTH)) begin
                lengthReg <= i_pwdata[NB_ADDRESS-1:0];
            end
            // a new block end wins over a clear in the same cycle
            if (i_changeBlock) begin
                blockDone <= 1'b1;
            end else if (apbDone && i_pwrite && (i_paddr == REG_STATUS)) begin
                blockDone <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_CLK) begin
        if (apbDone && i_pwrite && (i_paddr == REG_DATA)) begin
            pixelReg <= i_pwdata[NB_PIXEL-1:0];
        end
    end

    always_comb begin
        statusWord                = '0;
        statusWord[ST_BUSY]       = i_busy;
        statusWord[ST_EOP]        = i_eop;
        statusWord[ST_BLOCK_DONE] = blockDone;
    end

    always_comb begin
        o_prdata = '0;
        case (i_paddr)
            REG_CTRL: begin
                o_prdata[CTRL_LOAD]  = ctrlLoad;
                o_prdata[CTRL_START] = ctrlStart;
            end
            REG_LENGTH: o_prdata[NB_ADDRESS-1:0] = lengthReg;
            REG_DATA:   o_prdata[NB_RESULT-1:0]  = i_resultData;
            REG_STATUS: o_prdata = statusWord;
            default:    o_prdata = '0;
        endcase
    end

    assign o_pslverr   = 1'b0;
    assign o_load      = ctrlLoad;
    assign o_start     = ctrlStart;
    assign o_imgLength = lengthReg;
    assign o_dataPulse = dataPulse;
    assign o_pixelData = pixelReg;

endmodule

`default_nettype wire

// File: hdl/convTop.sv
`default_nettype none

module convTop import convDefs::*, apbMap::*; (
    input  logic                   i_CLK,
    input  logic                   i_reset,
    input  logic                   i_psel,
    input  logic                   i_penable,
    input  logic                   i_pwrite,
    input  logic [NB_APB_ADDR-1:0] i_paddr,
    input  logic [NB_APB_DATA-1:0] i_pwdata,
    output logic [NB_APB_DATA-1:0] o_prdata,
    output logic                   o_pready,
    output logic                   o_pslverr
);

    logic                  load;
    logic                  start;
    logic [NB_ADDRESS-1:0] imgLength;
    logic                  dataPulse;
    pixel_t                pixelData;
    pixel_t                pixelRd;
    result_t               resultData;
    result_t               resultWr;
    logic                  resultWe;
    logic                  busy;
    logic                  eop;
    logic                  changeBlock;
    logic                  imgWe;
    logic [NB_ADDRESS-1:0] imgWrAddr;
    logic [NB_ADDRESS-1:0] imgRdAddr;
    logic [NB_ADDRESS-1:0] resWrAddr;
    logic [NB_ADDRESS-1:0] resRdAddr;
    logic                  convValid;

    apbRegs apbRegs (
        .i_CLK(i_CLK), .i_reset(i_reset),
        .i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
        .i_paddr(i_paddr), .i_pwdata(i_pwdata),
        .i_busy(busy), .i_eop(eop), .i_changeBlock(changeBlock),
        .i_resultData(resultData),
        .o_prdata(o_prdata), .o_pready(o_pready), .o_pslverr(o_pslverr),
        .o_load(load), .o_start(start), .o_imgLength(imgLength),
        .o_dataPulse(dataPulse), .o_pixelData(pixelData)
    );

    blockSequencer blockSequencer (
        .i_CLK(i_CLK), .i_reset(i_reset),
        .i_load(load), .i_start(start), .i_dataPulse(dataPulse),
        .i_imgLength(imgLength), .i_resultWe(resultWe),
        .o_imgWe(imgWe), .o_imgWrAddr(imgWrAddr), .o_imgRdAddr(imgRdAddr),
        .o_resWrAddr(resWrAddr), .o_resRdAddr(resRdAddr),
        .o_convValid(convValid), .o_changeBlock(changeBlock),
        .o_eop(eop), .o_busy(busy)
    );

    lineRam #(.word_t(pixel_t)) imgRam (
        .i_CLK(i_CLK), .i_we(imgWe), .i_wrAddr(imgWrAddr), .i_wrData(pixelData),
        .i_rdAddr(imgRdAddr), .o_rdData(pixelRd)
    );

    smoothPipe smoothPipe (
        .i_CLK(i_CLK), .i_reset(i_reset),
        .i_valid(convValid), .i_pixel(pixelRd),
        .o_valid(resultWe), .o_result(resultWr)
    );

    lineRam #(.word_t(result_t)) resRam (
        .i_CLK(i_CLK), .i_we(resultWe), .i_wrAddr(resWrAddr), .i_wrData(resultWr),
        .i_rdAddr(resRdAddr), .o_rdData(resultData)
    );

endmodule

`default_nettype wire

// File: bench/convTop_tb.sv
`default_nettype none

module convTop_tb import apbMap::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int PREADY_LIMIT = 20;
    localparam int STATUS_LIMIT = 200;

    logic                   i_CLK;
    logic                   i_reset;
    logic                   i_psel;
    logic                   i_penable;
    logic                   i_pwrite;
    logic [NB_APB_ADDR-1:0] i_paddr;
    logic [NB_APB_DATA-1:0] i_pwdata;
    logic [NB_APB_DATA-1:0] o_prdata;
    logic                   o_pready;
    logic                   o_pslverr;

    logic [31:0] rngState;
    int          errorCount;
    int          testErrors;
    int          testsRun;
    int          testsFailed;
    string       testName;
    int          tokenQ[$];

    convTop i_dut (
        .i_CLK(i_CLK), .i_reset(i_reset),
        .i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
        .i_paddr(i_paddr), .i_pwdata(i_pwdata),
        .o_prdata(o_prdata), .o_pready(o_pready), .o_pslverr(o_pslverr)
    );

    always #20 i_CLK = ~i_CLK;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic checkValue(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("** Error %s/%s: expected 0x%0h, actual 0x%0h",
                     testName, what, expected, actual);
            errorCount++;
        end
    endtask

    task automatic beginTest(input string name);
        testName   = name;
        testErrors = errorCount;
    endtask

    task automatic endTest();
        testsRun++;
        if (errorCount == testErrors) begin
            $display("[pass] %s", testName);
        end else begin
            testsFailed++;
            $display("[fail] %s", testName);
        end
    endtask

    task automatic idleGap();
        int gap;
        rngState = xorshift(rngState);
        gap = rngState % 4;
        repeat (gap) @(posedge i_CLK);
    endtask

    // setup phase, access phase, then hold until PREADY
    task automatic apbTransfer(input logic write, input logic [NB_APB_ADDR-1:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output int waits);
        int cycles;
        idleGap();
        @(posedge i_CLK);
        i_psel    <= 1'b1;
        i_penable <= 1'b0;
        i_pwrite  <= write;
        i_paddr   <= addr;
        i_pwdata  <= wdata;
        @(posedge i_CLK);
        i_penable <= 1'b1;
        cycles = 0;
        @(negedge i_CLK);
        while (!o_pready && cycles < PREADY_LIMIT) begin
            cycles++;
            @(negedge i_CLK);
        end
        if (!o_pready) begin
            $display("timeout: PREADY never rose on access to offset 0x%0h", addr);
            $display("Test FAILED");
            $finish;
        end else begin
            rdata = o_prdata;
            waits = cycles;
            checkValue("pslverr", 0, o_pslverr);
            @(posedge i_CLK);
            i_psel    <= 1'b0;
            i_penable <= 1'b0;
        end
    endtask

    task automatic writeReg(input logic [NB_APB_ADDR-1:0] addr, input logic [31:0] data);
        logic [31:0] dummy;
        int          waits;
        apbTransfer(1'b1, addr, data, dummy, waits);
        checkValue("write wait states", 0, waits);
    endtask

    // register reads other than data complete without a wait state
    task automatic readReg(input logic [NB_APB_ADDR-1:0] addr, output logic [31:0] data);
        int waits;
        apbTransfer(1'b0, addr, 32'h0, data, waits);
        checkValue("read wait states", 0, waits);
    endtask

    // poll STATUS until a bit reaches the wanted level
    task automatic waitStatus(input int bitPos, input logic level);
        logic [31:0] status;
        int          polls;
        polls = 0;
        readReg(REG_STATUS, status);
        while (status[bitPos] !== level && polls < STATUS_LIMIT) begin
            polls++;
            readReg(REG_STATUS, status);
        end
        if (status[bitPos] !== level) begin
            $display("timeout: status bit %0d never reached %0b", bitPos, level);
            $display("Test FAILED");
            $finish;
        end
    endtask

    // hex tokens separated by blanks
    task automatic parseLine(input string line);
        int  value;
        bit  inToken;
        byte c;
        tokenQ.delete();
        value   = 0;
        inToken = 0;
        for (int i = 0; i < line.len(); i++) begin
            c = line[i];
            if (c >= "0" && c <= "9") begin
                value   = value * 16 + (c - "0");
                inToken = 1;
            end else if (c >= "A" && c <= "F") begin
                value   = value * 16 + (c - "A" + 10);
                inToken = 1;
            end else if (c >= "a" && c <= "f") begin
                value   = value * 16 + (c - "a" + 10);
                inToken = 1;
            end else if (inToken) begin
                tokenQ.push_back(value);
                value   = 0;
                inToken = 0;
            end
        end
        if (inToken) begin
            tokenQ.push_back(value);
        end
    endtask

    task automatic runBlock(input int blockNum);
        int          last;
        logic [31:0] rdata;
        int          waits;
        last = tokenQ[0];

        beginTest($sformatf("load_block%0d", blockNum));
        writeReg(REG_STATUS, 32'h0);
        writeReg(REG_LENGTH, last);
        writeReg(REG_CTRL, 32'h1 << CTRL_LOAD);
        for (int i = 0; i < last; i++) begin
            writeReg(REG_DATA, tokenQ[1 + i]);
        end
        // load drops before the final pixel so the FSM settles in idle
        writeReg(REG_CTRL, 32'h0);
        writeReg(REG_DATA, tokenQ[1 + last]);
        waitStatus(ST_BLOCK_DONE, 1'b1);
        readReg(REG_STATUS, rdata);
        checkValue("status", 32'h1 << ST_BLOCK_DONE, rdata);
        endTest();

        beginTest($sformatf("process_block%0d", blockNum));
        writeReg(REG_STATUS, 32'h0);
        writeReg(REG_CTRL, 32'h1 << CTRL_START);
        waitStatus(ST_EOP, 1'b1);
        writeReg(REG_CTRL, 32'h0);
        // start released with results pending, so the readout is under way
        readReg(REG_STATUS, rdata);
        checkValue("status", (32'h1 << ST_EOP) | (32'h1 << ST_BUSY), rdata);
        endTest();

        beginTest($sformatf("readout_block%0d", blockNum));
        for (int i = 0; i <= last; i++) begin
            apbTransfer(1'b0, REG_DATA, 32'h0, rdata, waits);
            checkValue($sformatf("result[%0d]", i), tokenQ[2 + last + i], rdata);
            checkValue($sformatf("wait states[%0d]", i), 1, waits);
        end
        waitStatus(ST_BLOCK_DONE, 1'b1);
        readReg(REG_STATUS, rdata);
        checkValue("eop after readout", 0, rdata[ST_EOP]);
        checkValue("busy after readout", 0, rdata[ST_BUSY]);
        endTest();
    endtask

    initial begin
        int          fd;
        int          blockNum;
        string       line;
        logic [31:0] rdata;
        i_CLK       = 1'b0;
        i_reset     = 1'b1;
        i_psel      = 1'b0;
        i_penable   = 1'b0;
        i_pwrite    = 1'b0;
        i_paddr     = '0;
        i_pwdata    = '0;
        rngState    = 32'd77100;
        errorCount  = 0;
        testsRun    = 0;
        testsFailed = 0;
        blockNum    = 0;

        repeat (8) @(posedge i_CLK);
        i_reset <= 1'b0;

        beginTest("reset_status");
        readReg(REG_STATUS, rdata);
        checkValue("status", 0, rdata);
        endTest();

        fd = $fopen("bench/testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open bench/testdata.txt");
            $display("Test FAILED");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) != 0 && line.len() > 0 && line[0] != "#") begin
                    parseLine(line);
                    if (tokenQ.size() == 0) begin
                        continue;
                    end
                    if (tokenQ.size() != 3 + 2 * tokenQ[0]) begin
                        $display("malformed data line for block %0d", blockNum);
                        errorCount++;
                    end else begin
                        runBlock(blockNum);
                        blockNum++;
                    end
                end
            end
            $fclose(fd);

            beginTest("status_clear_length");
            checkValue("blocks read", 2, blockNum);
            writeReg(REG_STATUS, 32'h0);
            readReg(REG_STATUS, rdata);
            checkValue("status", 0, rdata);
            writeReg(REG_LENGTH, 32'h1A5);
            readReg(REG_LENGTH, rdata);
            checkValue("length", 32'h1A5, rdata);
            endTest();

            $display("tests run %0d, failed %0d, check errors %0d",
                     testsRun, testsFailed, errorCount);
            if (errorCount == 0) begin
                $display("Test OK");
            end else begin
                $display("Test FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: bench/testdata.txt
# one block per line, hex: last index L, then L+1 pixels, then L+1 expected results
# expected y[n] = x[n] + 2*x[n-1] + x[n-2], samples before the block are zero
7 10 20 30 40 FF 00 80 05 10 40 80 C0 1AF 23E 17F 105
4 FF FF FF 01 02 FF 2FD 3FC 2FE 103

// File: convTop.f
hdl/convDefs.sv
hdl/apbMap.sv
hdl/lineRam.sv
hdl/blockSequencer.sv
hdl/smoothPipe.sv
hdl/apbRegs.sv
hdl/convTop.sv
bench/convTop_tb.sv
